//--- Makefile
# Verilator build and run for the rv_core testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
+incdir+include
design/rv_pkg.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_execute.sv
design/rv_retire.sv
design/rv_core.sv
testbench/tb_rv_core.sv

//--- design/rv_core.sv
`default_nettype none

module rv_core (
  input  wire                          clk,
  input  wire                          rst,
  input  wire  [rv_pkg::xlen-1:0]      insn,
  output logic [rv_pkg::xlen-1:0]      pc,
  output logic                         halt,
  output logic                         retire_valid,
  output logic [rv_pkg::reg_idx_w-1:0] retire_rd,
  output logic [rv_pkg::xlen-1:0]      retire_data
);
  import rv_pkg::*;

  logic [reg_idx_w-1:0] rs1_idx;
  logic [reg_idx_w-1:0] rs2_idx;
  logic [reg_idx_w-1:0] rd_idx;
  logic [xlen-1:0]      imm;
  logic [xlen-1:0]      rs1_data;
  logic [xlen-1:0]      rs2_data;
  logic [xlen-1:0]      alu_result;
  logic [xlen-1:0]      rf_wdata;
  logic                 use_imm;
  logic                 use_pc;
  logic                 is_ecall;
  logic                 branch_taken;
  logic                 rf_we;
  alu_op_e              alu_op;
  br_op_e               br_op;
  wb_sel_e              wb_sel;
  pc_sel_e              pc_sel;

  rv_decoder u_decoder (
    .insn     (insn),
    .rs1_idx  (rs1_idx),
    .rs2_idx  (rs2_idx),
    .rd_idx   (rd_idx),
    .imm      (imm),
    .use_imm  (use_imm),
    .use_pc   (use_pc),
    .alu_op   (alu_op),
    .br_op    (br_op),
    .wb_sel   (wb_sel),
    .pc_sel   (pc_sel),
    .is_ecall (is_ecall)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .we       (rf_we),
    .rd_idx   (rd_idx),
    .wdata    (rf_wdata),
    .rs1_idx  (rs1_idx),
    .rs2_idx  (rs2_idx),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_execute u_execute (
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .imm          (imm),
    .pc           (pc),
    .use_imm      (use_imm),
    .use_pc       (use_pc),
    .alu_op       (alu_op),
    .br_op        (br_op),
    .alu_result   (alu_result),
    .branch_taken (branch_taken)
  );

  rv_retire u_retire (
    .clk          (clk),
    .rst          (rst),
    .insn_rd      (rd_idx),
    .wb_sel       (wb_sel),
    .pc_sel       (pc_sel),
    .is_ecall     (is_ecall),
    .alu_result   (alu_result),
    .branch_taken (branch_taken),
    .imm          (imm),
    .rs1_data     (rs1_data),
    .pc           (pc),
    .halt         (halt),
    .rf_we        (rf_we),
    .rf_wdata     (rf_wdata)
  );

  // Retire strobe is the register-file write port
  assign retire_valid = rf_we;
  assign retire_rd    = rd_idx;
  assign retire_data  = rf_wdata;

endmodule

`default_nettype wire

//--- design/rv_decoder.sv
`default_nettype none

module rv_decoder (
  input  wire  [rv_pkg::xlen-1:0]      insn,
  output logic [rv_pkg::reg_idx_w-1:0] rs1_idx,
  output logic [rv_pkg::reg_idx_w-1:0] rs2_idx,
  output logic [rv_pkg::reg_idx_w-1:0] rd_idx,
  output logic [rv_pkg::xlen-1:0]      imm,
  output logic                         use_imm,
  output logic                         use_pc,
  output rv_pkg::alu_op_e              alu_op,
  output rv_pkg::br_op_e               br_op,
  output rv_pkg::wb_sel_e              wb_sel,
  output rv_pkg::pc_sel_e              pc_sel,
  output logic                         is_ecall
);
  import rv_pkg::*;

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_j;
  logic [xlen-1:0] imm_u;

  // ALU operation shared by the immediate and register groups
  function automatic alu_op_e base_op(input logic [2:0] f3);
    case (f3)
      3'b000:  return alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  assign opcode  = insn[6:0];
  assign rd_idx  = insn[11:7];
  assign funct3  = insn[14:12];
  assign rs1_idx = insn[19:15];
  assign rs2_idx = insn[24:20];
  assign funct7  = insn[31:25];

  // Sign-extended immediates
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  always_comb begin
    imm      = imm_i;
    use_imm  = 1'b0;
    use_pc   = 1'b0;
    alu_op   = alu_add;
    br_op    = br_eq;
    wb_sel   = wb_none;   // Anything unrecognised runs as a no-op
    pc_sel   = pc_seq;
    is_ecall = 1'b0;
    case (opcode)
      op_lui: begin
        imm     = imm_u;
        use_imm = 1'b1;
        alu_op  = alu_pass_b;
        wb_sel  = wb_alu;
      end
      op_auipc: begin
        imm     = imm_u;
        use_imm = 1'b1;
        use_pc  = 1'b1;
        wb_sel  = wb_alu;
      end
      op_jal: begin
        imm    = imm_j;
        wb_sel = wb_pc_plus4;
        pc_sel = pc_jal;
      end
      op_jalr: begin
        if (funct3 == 3'b000) begin
          wb_sel = wb_pc_plus4;
          pc_sel = pc_jalr;
        end
      end
      op_branch: begin
        imm = imm_b;
        case (funct3)
          3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111: begin
            br_op  = br_op_e'(funct3);
            pc_sel = pc_branch;
          end
          default: pc_sel = pc_seq;
        endcase
      end
      op_reg_imm: begin
        use_imm = 1'b1;
        alu_op  = base_op(funct3);
        if (funct3 == 3'b001) begin
          if (funct7 == 7'b0000000) wb_sel = wb_alu;
        end else if (funct3 == 3'b101) begin
          if (funct7 == 7'b0000000) begin
            wb_sel = wb_alu;
          end else if (funct7 == 7'b0100000) begin
            alu_op = alu_sra;   // SRAI
            wb_sel = wb_alu;
          end
        end else begin
          wb_sel = wb_alu;
        end
      end
      op_reg_reg: begin
        if (funct7 == 7'b0000000) begin
          alu_op = base_op(funct3);
          wb_sel = wb_alu;
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          alu_op = alu_sub;
          wb_sel = wb_alu;
        end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
          alu_op = alu_sra;
          wb_sel = wb_alu;
        end
      end
      op_system: is_ecall = (insn[31:7] == '0);  // Other system words fall through
      default: wb_sel = wb_none;                   // FENCE lands here as well
    endcase
  end

endmodule

`default_nettype wire

//--- design/rv_execute.sv
`default_nettype none

module rv_execute (
  input  wire  [rv_pkg::xlen-1:0] rs1_data,
  input  wire  [rv_pkg::xlen-1:0] rs2_data,
  input  wire  [rv_pkg::xlen-1:0] imm,
  input  wire  [rv_pkg::xlen-1:0] pc,
  input  wire                     use_imm,
  input  wire                     use_pc,
  input  wire  rv_pkg::alu_op_e   alu_op,
  input  wire  rv_pkg::br_op_e    br_op,
  output logic [rv_pkg::xlen-1:0] alu_result,
  output logic                    branch_taken
);
  import rv_pkg::*;

  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [4:0]      shamt;

  assign op_a  = use_pc ? pc : rs1_data;     // pc only for AUIPC
  assign op_b  = use_imm ? imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (alu_op)
      alu_add:    alu_result = op_a + op_b;
      alu_sub:    alu_result = op_a - op_b;
      alu_sll:    alu_result = op_a << shamt;
      alu_slt:    alu_result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_sltu:   alu_result = {{(xlen-1){1'b0}}, op_a < op_b};
      alu_xor:    alu_result = op_a ^ op_b;
      alu_srl:    alu_result = op_a >> shamt;
      alu_sra:    alu_result = $signed(op_a) >>> shamt;
      alu_or:     alu_result = op_a | op_b;
      alu_and:    alu_result = op_a & op_b;
      alu_pass_b: alu_result = op_b;
      default:    alu_result = op_a + op_b;
    endcase
  end

  // Comparator always looks at the two registers
  always_comb begin
    case (br_op)
      br_eq:   branch_taken = (rs1_data == rs2_data);
      br_ne:   branch_taken = (rs1_data != rs2_data);
      br_lt:   branch_taken = $signed(rs1_data) < $signed(rs2_data);
      br_ge:   branch_taken = $signed(rs1_data) >= $signed(rs2_data);
      br_ltu:  branch_taken = (rs1_data < rs2_data);
      br_geu:  branch_taken = (rs1_data >= rs2_data);
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- design/rv_pkg.sv
`default_nettype none

package rv_pkg;

  // Datapath widths
  localparam int xlen      = 32;
  localparam int reg_idx_w = 5;
  localparam int num_regs  = 32;

  localparam logic [xlen-1:0] reset_pc = '0;
  localparam logic [xlen-1:0] pc_step  = 32'd4;   // One instruction word

  // Major opcodes of the RV32I subset the core executes
  typedef enum logic [6:0] {
    op_lui      = 7'b0110111,
    op_auipc    = 7'b0010111,
    op_jal      = 7'b1101111,
    op_jalr     = 7'b1100111,
    op_branch   = 7'b1100011,
    op_misc_mem = 7'b0001111,   // FENCE
    op_reg_imm  = 7'b0010011,
    op_reg_reg  = 7'b0110011,
    op_system   = 7'b1110011    // ECALL
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b   // LUI passes the U immediate through
  } alu_op_e;

  // Values match the funct3 field of the branch group
  typedef enum logic [2:0] {
    br_eq  = 3'b000,
    br_ne  = 3'b001,
    br_lt  = 3'b100,
    br_ge  = 3'b101,
    br_ltu = 3'b110,
    br_geu = 3'b111
  } br_op_e;

  typedef enum logic [1:0] {
    wb_alu,
    wb_pc_plus4,  // Link address for JAL and JALR
    wb_none
  } wb_sel_e;

  typedef enum logic [1:0] {
    pc_seq,
    pc_branch,    // pc + imm when taken
    pc_jal,
    pc_jalr
  } pc_sel_e;

endpackage

`default_nettype wire

//--- design/rv_regfile.sv
`default_nettype none

module rv_regfile (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          we,
  input  wire  [rv_pkg::reg_idx_w-1:0] rd_idx,
  input  wire  [rv_pkg::xlen-1:0]      wdata,
  input  wire  [rv_pkg::reg_idx_w-1:0] rs1_idx,
  input  wire  [rv_pkg::reg_idx_w-1:0] rs2_idx,
  output logic [rv_pkg::xlen-1:0]      rs1_data,
  output logic [rv_pkg::xlen-1:0]      rs2_data
);
  import rv_pkg::*;

  // x0 has no storage
  logic [xlen-1:0] regs [1:num_regs-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd_idx != '0) begin
      regs[rd_idx] <= wdata;
    end
  end

  // Combinational reads, new data seen the cycle after the write
  assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
  assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

`default_nettype wire

//--- design/rv_retire.sv
`default_nettype none

module rv_retire (
  input  wire                          clk,
  input  wire                          rst,
  input  wire  [rv_pkg::reg_idx_w-1:0] insn_rd,
  input  wire  rv_pkg::wb_sel_e        wb_sel,
  input  wire  rv_pkg::pc_sel_e        pc_sel,
  input  wire                          is_ecall,
  input  wire  [rv_pkg::xlen-1:0]      alu_result,
  input  wire                          branch_taken,
  input  wire  [rv_pkg::xlen-1:0]      imm,
  input  wire  [rv_pkg::xlen-1:0]      rs1_data,
  output logic [rv_pkg::xlen-1:0]      pc,
  output logic                         halt,
  output logic                         rf_we,
  output logic [rv_pkg::xlen-1:0]      rf_wdata
);
  import rv_pkg::*;

  // Boot is the idle cycle after reset, nothing retires in it
  typedef enum logic [1:0] {
    st_boot,
    st_run,
    st_halt
  } state_e;

  state_e          state;
  state_e          state_next;
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] pc_rel;
  logic [xlen-1:0] jalr_sum;
  logic [xlen-1:0] pc_next;

  assign pc_plus4 = pc + pc_step;
  assign pc_rel   = pc + imm;         // Branch and JAL target
  assign jalr_sum = rs1_data + imm;

  always_comb begin
    case (pc_sel)
      pc_branch: pc_next = branch_taken ? pc_rel : pc_plus4;
      pc_jal:    pc_next = pc_rel;
      pc_jalr:   pc_next = {jalr_sum[xlen-1:1], 1'b0};
      default:   pc_next = pc_plus4;
    endcase
  end

  always_comb begin
    state_next = state;
    case (state)
      st_boot: state_next = st_run;
      st_run: begin
        if (is_ecall) state_next = st_halt;
      end
      default: state_next = state;   // Halt is left only through reset
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_boot;
      pc    <= reset_pc;
    end else begin
      state <= state_next;
      if (state == st_run) pc <= pc_next;
    end
  end

  assign halt = (state == st_halt);

  // Write-back, x0 and no-op words never write
  assign rf_we    = (state == st_run) && (wb_sel != wb_none) && (insn_rd != '0);
  assign rf_wdata = (wb_sel == wb_pc_plus4) ? pc_plus4 : alu_result;

endmodule

`default_nettype wire

//--- include/tb_rv_asm.svh
`ifndef TB_RV_ASM_SVH
`define TB_RV_ASM_SVH

// Reference register file with x0 held at zero
typedef logic [31:0] ref_rf_t [32];

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, rv_pkg::op_reg_reg};
endfunction

function automatic logic [31:0] enc_i(input rv_pkg::opcode_e op, input logic [11:0] imm,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_u(input rv_pkg::opcode_e op, input logic [4:0] rd,
                                      input logic [19:0] imm);
  return {imm, rd, op};
endfunction

// Byte offsets with bit 0 dropped
function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                      input logic [4:0] rs2, input logic [12:0] off);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::op_branch};
endfunction

function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] off);
  return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::op_jal};
endfunction

function automatic logic [31:0] enc_ecall();
  return {25'd0, rv_pkg::op_system};
endfunction

// alt selects SUB and SRA
function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
  case (f3)
    3'b000:  return alt ? a - b : a + b;
    3'b001:  return a << b[4:0];
    3'b010:  return {31'd0, $signed(a) < $signed(b)};
    3'b011:  return {31'd0, a < b};
    3'b100:  return a ^ b;
    3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'b110:  return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic ref_branch(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
  case (f3)
    3'b000:  return a == b;
    3'b001:  return a != b;
    3'b100:  return $signed(a) < $signed(b);
    3'b101:  return $signed(a) >= $signed(b);
    3'b110:  return a < b;
    default: return a >= b;
  endcase
endfunction

`endif

//--- testbench/tb_rv_core.sv
`default_nettype none

module tb_rv_core;
  timeunit 1ns;
  timeprecision 1ns;

  import rv_pkg::*;

  `include "tb_rv_asm.svh"

  localparam int prog_depth   = 256;
  localparam int halt_timeout = 2000;   // Cycles allowed for the whole program

  typedef enum logic [1:0] {
    m_boot,
    m_run,
    m_halt
  } model_state_e;

  logic        clk;
  logic        rst  = 1'b1;
  logic [31:0] insn = 32'd0;
  logic [31:0] pc;
  logic        halt;
  logic        retire_valid;
  logic [4:0]  retire_rd;
  logic [31:0] retire_data;

  logic [31:0]  prog [prog_depth];
  int           prog_len;
  integer       seed;

  // Reference model state and the expectations for the current cycle
  model_state_e m_state;
  logic [31:0]  m_pc;
  ref_rf_t      m_rf;
  logic         exp_we;
  logic [4:0]   exp_rd;
  logic [31:0]  exp_data;
  logic [31:0]  exp_npc;
  logic         exp_ecall;

  rv_core u_rv_core (
    .clk          (clk),
    .rst          (rst),
    .insn         (insn),
    .pc           (pc),
    .halt         (halt),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    abort_run($sformatf("[ERROR] %s expected 0x%08h got 0x%08h", name, exp_val, act_val));
  endtask

  // Opcode zero is outside the kept set, so unused words run as no-ops
  function automatic logic [31:0] fill_word(input logic [31:0] idx);
    return {idx[24:0] ^ {20'd0, idx[29:25]}, 7'd0};
  endfunction

  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    if (addr[31:2] < prog_depth) return prog[addr[31:2]];
    return fill_word(addr[31:2]);
  endfunction

  task automatic emit(input logic [31:0] word);
    prog[prog_len] = word;
    prog_len++;
  endtask

  // LUI plus ADDI with the upper part rounded for the sign of the low 12 bits
  task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] hi;
    hi = value + 32'h800;
    emit(enc_u(op_lui, rd, hi[31:12]));
    emit(enc_i(op_reg_imm, value[11:0], rd, 3'b000, rd));
  endtask

  // Combinational instruction memory
  always @(negedge clk) begin
    insn <= fetch_word(pc);
  end

  always_comb begin : ref_decode
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] imm_u;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        wr;
    a     = m_rf[insn[19:15]];   // Entry 0 stays zero
    b     = m_rf[insn[24:20]];
    f3    = insn[14:12];
    f7    = insn[31:25];
    imm_i = {{20{insn[31]}}, insn[31:20]};
    imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
    imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
    imm_u = {insn[31:12], 12'd0};
    wr        = 1'b0;
    exp_rd    = insn[11:7];
    exp_data  = 32'd0;
    exp_npc   = m_pc + 32'd4;
    exp_ecall = 1'b0;
    case (insn[6:0])
      op_lui: begin
        wr       = 1'b1;
        exp_data = imm_u;
      end
      op_auipc: begin
        wr       = 1'b1;
        exp_data = m_pc + imm_u;
      end
      op_jal: begin
        wr       = 1'b1;
        exp_data = m_pc + 32'd4;
        exp_npc  = m_pc + imm_j;
      end
      op_jalr: begin
        if (f3 == 3'b000) begin
          wr       = 1'b1;
          exp_data = m_pc + 32'd4;
          exp_npc  = (a + imm_i) & ~32'd1;
        end
      end
      op_branch: begin
        if (f3 != 3'b010 && f3 != 3'b011 && ref_branch(f3, a, b)) exp_npc = m_pc + imm_b;
      end
      op_reg_imm: begin
        if (f3 == 3'b001) wr = (f7 == 7'h00);
        else if (f3 == 3'b101) wr = (f7 == 7'h00) || (f7 == 7'h20);
        else wr = 1'b1;
        exp_data = ref_alu(f3, f7[5] && f3 == 3'b101, a, imm_i);
      end
      op_reg_reg: begin
        wr       = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
        exp_data = ref_alu(f3, f7[5], a, b);
      end
      op_system: exp_ecall = (insn[31:7] == 25'd0);
      default: wr = 1'b0;   // FENCE and unknown words
    endcase
    exp_we = wr && exp_rd != 5'd0 && m_state == m_run;
  end

  always @(posedge clk) begin
    if (rst) begin
      m_state <= m_boot;
      m_pc    <= reset_pc;
      for (int i = 0; i < 32; i++) begin
        m_rf[i] <= 32'd0;
      end
    end else begin
      case (m_state)
        m_boot: m_state <= m_run;   // Nothing retires in the first cycle
        m_run: begin
          m_pc <= exp_npc;
          if (exp_we) m_rf[exp_rd] <= exp_data;
          if (exp_ecall) m_state <= m_halt;
        end
        default: m_state <= m_halt;
      endcase
    end
  end

  a_reset_state: assert property (@(posedge clk) disable iff (rst)
      m_state == m_boot |-> pc == reset_pc && !halt && !retire_valid)
    else abort_run("core was not idle at pc zero in the cycle after reset");
  a_pc: assert property (@(posedge clk) disable iff (rst) pc == m_pc)
    else report_mismatch("pc", $sampled(m_pc), $sampled(pc));
  a_valid: assert property (@(posedge clk) disable iff (rst) retire_valid == exp_we)
    else report_mismatch("retire_valid", 32'($sampled(exp_we)), 32'($sampled(retire_valid)));
  a_rd: assert property (@(posedge clk) disable iff (rst) retire_valid |-> retire_rd == exp_rd)
    else report_mismatch("retire_rd", 32'($sampled(exp_rd)), 32'($sampled(retire_rd)));
  a_data: assert property (@(posedge clk) disable iff (rst)
      retire_valid |-> retire_data == exp_data)
    else report_mismatch("retire_data", $sampled(exp_data), $sampled(retire_data));
  a_halt: assert property (@(posedge clk) disable iff (rst) halt == (m_state == m_halt))
    else report_mismatch("halt", 32'($sampled(m_state == m_halt)), 32'($sampled(halt)));
  a_ecall: assert property (@(posedge clk) disable iff (rst)
      m_state == m_run && exp_ecall |=> halt)
    else abort_run("halt did not rise on the edge after ECALL");
  a_halt_pc: assert property (@(posedge clk) disable iff (rst) halt |=> $stable(pc))
    else abort_run("pc moved while the core was halted");
  a_halt_quiet: assert property (@(posedge clk) disable iff (rst) halt |-> !retire_valid)
    else abort_run("retire strobe seen while the core was halted");

  initial begin
    logic [31:0] rnd;
    logic [11:0] imm;
    int          cycles;
    seed     = 32'h988c;
    prog_len = 0;
    for (int i = 0; i < prog_depth; i++) begin
      prog[i] = fill_word(32'(i));
    end

    // Random operands in x1 and x2 with results in x10 to x28
    for (int r = 0; r < 4; r++) begin
      load_const(5'd1, $random(seed));
      load_const(5'd2, $random(seed));
      for (int f3 = 0; f3 < 8; f3++) begin
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'(f3), 5'(10 + f3)));
      end
      emit(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd18));   // SUB
      emit(enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd19));   // SRA
      for (int f3 = 0; f3 < 8; f3++) begin
        rnd = $random(seed);
        imm = (f3 == 1 || f3 == 5) ? {7'h00, rnd[4:0]} : rnd[11:0];
        emit(enc_i(op_reg_imm, imm, 5'd1, 3'(f3), 5'(20 + f3)));
      end
      rnd = $random(seed);
      emit(enc_i(op_reg_imm, {7'h20, rnd[4:0]}, 5'd1, 3'b101, 5'd28));   // SRAI
    end

    // Each condition over three pairs, so every one is both taken and not taken
    load_const(5'd6, 32'hffff_fffb);
    load_const(5'd7, 32'd3);
    load_const(5'd8, 32'd3);
    for (int f3 = 0; f3 < 8; f3++) begin
      if (f3 != 2 && f3 != 3) begin
        for (int p = 0; p < 3; p++) begin
          emit(enc_b(3'(f3), (p == 0) ? 5'd6 : 5'd7, (p == 0) ? 5'd7 : (p == 1) ? 5'd6 : 5'd8,
                     13'd8));
          emit(enc_i(op_reg_imm, 12'd1, 5'd9, 3'b000, 5'd9));   // Skipped when taken
        end
      end
    end

    emit(enc_j(5'd1, 21'd12));
    emit(enc_i(op_reg_imm, 12'd7, 5'd9, 3'b000, 5'd9));
    emit(enc_i(op_reg_imm, 12'd7, 5'd9, 3'b000, 5'd9));
    emit(enc_u(op_auipc, 5'd11, 20'd0));
    emit(enc_i(op_jalr, 12'd13, 5'd11, 3'b000, 5'd12));   // Odd target lands on auipc + 12
    emit(enc_i(op_reg_imm, 12'd7, 5'd9, 3'b000, 5'd9));
    rnd = $random(seed);
    emit(enc_u(op_auipc, 5'd13, rnd[19:0]));

    // x0 writes, FENCE and words outside the kept set
    emit(enc_i(op_reg_imm, 12'h5a5, 5'd1, 3'b000, 5'd0));
    emit(enc_u(op_lui, 5'd0, rnd[31:12]));
    emit(enc_j(5'd0, 21'd4));
    emit(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd14));
    emit(enc_i(op_misc_mem, 12'h0ff, 5'd0, 3'b000, 5'd0));
    emit(32'hffff_ffff);
    emit(enc_r(7'h01, 5'd2, 5'd1, 3'b000, 5'd15));   // MUL is not executed
    emit(enc_ecall());

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst <= 1'b0;

    cycles = 0;
    while (!halt && cycles < halt_timeout) begin
      @(negedge clk);
      cycles++;
    end
    if (!halt) begin
      abort_run($sformatf("core did not halt within %0d cycles", halt_timeout));
    end else begin
      repeat (20) @(negedge clk);   // Halted core must stay frozen
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire
